//--- all.f
+incdir+.
dmi_pkg.sv
dm_reg_pkg.sv
dmi_resp_fifo.sv
dm_csr_decode.sv
dm_hart_ctrl.sv
dm_abstract_regs.sv
dm_csrs_top.sv
tb_dm_csrs.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_dm_csrs -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q "PASS: all tests"; then
  exit 0
fi
exit 1

//--- tb_dm_csrs.sv
// ----------------------------------------------------------
// self-checking testbench for the debug module register front
// runs random DMI traffic against a register model
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dm_config.svh"

module tb_dm_csrs
  import dmi_pkg::*;
  import dm_reg_pkg::*;
;

  localparam int MaxCycles = 4000;

  logic clk_i = 1'b0, rst_ni = 1'b0, dmi_rst_ni_i = 1'b1;
  logic dmi_req_valid_i, dmi_req_ready_o, dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_req_t  dmi_req_i;
  dmi_resp_t dmi_resp_o;
  logic [`DM_NR_HARTS-1:0] halted_i, unavailable_i, resumeack_i, haltreq_o, resumereq_o;
  logic clear_resumeack_o, ndmreset_o, dmactive_o, cmd_valid_o;
  command_t cmd_o;
  logic cmderror_valid_i, cmdbusy_i;
  cmderr_e cmderror_i;
  logic [`DM_DATA_COUNT-1:0][31:0]   data_o;
  logic [`DM_PROGBUF_SIZE-1:0][31:0] progbuf_o;

  // register model
  logic [31:0] m_dmctl, m_command;
  logic [3:0]  m_havereset;
  logic [2:0]  m_cmderr;
  logic [31:0] m_data [`DM_DATA_COUNT];
  logic [31:0] m_prog [`DM_PROGBUF_SIZE];
  logic [31:0] exp_data [$];
  logic [1:0]  exp_code [$];

  logic [31:0] rng_state = 32'd85;
  int cycles = 0, checks = 0, errors = 0, tests = 0, test_errs = 0, pulses = 0;
  int resume_clears = 0;
  logic [31:0] last_cmd;

  dm_csrs_top uut (.*);

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic logic [31:0] rand32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  task automatic check(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("FAILED at %0t: %s", $time, msg);
    end
  endtask

  // responses are compared in order against the model queue
  always @(negedge clk_i) begin
    if (cmd_valid_o) begin
      pulses++;
      last_cmd = cmd_o;
    end
    if (clear_resumeack_o) begin
      resume_clears++;
    end
    if (rst_ni && dmi_resp_valid_o && dmi_resp_ready_i) begin
      if (exp_data.size() == 0) begin
        check(1'b0, "response arrived with no request outstanding");
      end else begin
        check(dmi_resp_o.data == exp_data[0] && dmi_resp_o.resp == exp_code[0],
              $sformatf("response %h/%0d, expected %h/%0d", dmi_resp_o.data,
                        dmi_resp_o.resp, exp_data[0], exp_code[0]));
        void'(exp_data.pop_front());
        void'(exp_code.pop_front());
      end
    end
  end

  // dmstatus as the spec rules give it for the selected hart
  function automatic logic [31:0] status_word();
    logic [19:0] hs;
    logic [1:0]  s;
    logic        ex, h, u, ra, hr, run;
    logic [31:0] w;
    hs  = {m_dmctl[15:6], m_dmctl[25:16]};
    s   = hs[1:0];
    ex  = hs < `DM_NR_HARTS;
    h   = ex & halted_i[s] & ~unavailable_i[s];
    u   = ex & unavailable_i[s];
    ra  = ex & resumeack_i[s];
    hr  = ex & m_havereset[s];
    run = ex & ~halted_i[s] & ~unavailable_i[s];
    w = 32'h0000_0082;
    w[9:8]   = {h, h};
    w[11:10] = {run, run};
    w[13:12] = {u, u};
    w[15:14] = {~ex, ~ex};
    w[17:16] = {ra, ra};
    w[19:18] = {hr, hr};
    return w;
  endfunction

  function automatic logic [31:0] predict_read(input logic [7:0] a);
    if (a >= 8'h04 && a < 8'h04 + `DM_DATA_COUNT) return m_data[a - 8'h04];
    if (a >= 8'h20 && a < 8'h20 + `DM_PROGBUF_SIZE) return m_prog[a - 8'h20];
    case (a)
      8'h10:   return m_dmctl;
      8'h11:   return status_word();
      8'h16:   return 32'h0400_0002 | {cmdbusy_i, 1'b0, m_cmderr, 8'h0};
      8'h40:   return {28'b0, halted_i};
      default: return 32'h0;
    endcase
  endfunction

  task automatic model_write(input logic [7:0] a, input logic [31:0] w);
    logic [19:0] hs;
    hs = {m_dmctl[15:6], m_dmctl[25:16]};
    if (a == 8'h10) begin
      if (!(m_dmctl[0] && w[0])) begin
        m_dmctl     = {31'b0, w[0]};
        m_havereset = '1;
        if (!w[0]) begin
          m_data    = '{default: '0};
          m_prog    = '{default: '0};
          m_command = '0;
          m_cmderr  = '0;
        end
      end else begin
        if (w[28] && hs < `DM_NR_HARTS) m_havereset[hs[1:0]] = 1'b0;
        // ndmreset keeps every hart in havereset
        if (m_dmctl[1] || w[1]) m_havereset = '1;
        m_dmctl = w & 32'hC3FF_FFC3;
      end
    end else if (a >= 8'h04 && a < 8'h04 + `DM_DATA_COUNT) begin
      m_data[a - 8'h04] = w;
    end else if (a >= 8'h20 && a < 8'h20 + `DM_PROGBUF_SIZE) begin
      m_prog[a - 8'h20] = w;
    end else if (a == 8'h16) begin
      m_cmderr = m_cmderr & ~w[10:8];
    end else if (a == 8'h17) begin
      m_command = w;
    end
  endtask

  // drive one request and hold it until accepted
  task automatic send(input logic wr, input logic [7:0] a, input logic [31:0] w);
    logic acc, abs_reg, busy;
    abs_reg = (a >= 8'h04 && a < 8'h04 + `DM_DATA_COUNT) ||
              (a >= 8'h20 && a < 8'h20 + `DM_PROGBUF_SIZE);
    busy = cmdbusy_i && (abs_reg || (wr && (a == 8'h16 || a == 8'h17)));
    exp_data.push_back(wr ? 32'h0 : predict_read(a));
    exp_code.push_back(busy ? 2'h3 : 2'h0);
    if (busy && m_cmderr == 3'h0) m_cmderr = 3'h1;
    if (wr && !busy) model_write(a, w);
    dmi_req_i.addr  = a[6:0];
    dmi_req_i.op    = wr ? DTM_WRITE : DTM_READ;
    dmi_req_i.data  = w;
    dmi_req_valid_i = 1'b1;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk_i);
      acc = dmi_req_ready_o;
      @(posedge clk_i);
      #1;
    end
    dmi_req_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_data.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic access(input logic wr, input logic [7:0] a, input logic [31:0] w);
    send(wr, a, w);
    drain();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %s", tests, name, (errors == test_errs) ? "ok" : "errors");
    test_errs = errors;
  endtask

  initial begin
    logic [31:0] w, v;
    logic [3:0]  h;
    dmi_req_valid_i = 0;
    dmi_req_i = '0;
    dmi_resp_ready_i = 1;
    halted_i = 0;
    unavailable_i = 0;
    resumeack_i = 0;
    cmderror_valid_i = 0;
    cmderror_i = CmdErrNone;
    cmdbusy_i = 0;
    m_dmctl = 0;
    m_havereset = '1;
    m_cmderr = 0;
    m_command = 0;
    m_data = '{default: '0};
    m_prog = '{default: '0};
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // ------------------------------------------------------
    // dmcontrol and dmactive
    // ------------------------------------------------------
    access(1, 8'h10, 32'h1);
    access(0, 8'h10, 0);
    for (int i = 0; i < 8; i++) begin
      access(1, 8'h10, rand32() | 32'h1);
      access(0, 8'h10, 0);
      check(dmactive_o == m_dmctl[0] && ndmreset_o == m_dmctl[1],
            "dmactive_o or ndmreset_o wrong");
    end
    access(1, 8'h04, rand32());
    access(1, 8'h10, 32'h0);
    access(0, 8'h10, 0);
    access(0, 8'h04, 0);
    check(dmactive_o == 1'b0 && ndmreset_o == 1'b0, "dmactive_o or ndmreset_o not cleared");
    access(1, 8'h10, 32'h1);
    end_test("dmcontrol");

    for (int i = 0; i < 8; i++) begin
      h = rand32() % 6;
      access(1, 8'h10, 32'h8000_0001 | (32'(h) << 16));
      check(haltreq_o == ((h < `DM_NR_HARTS) ? 4'(1 << h) : 4'h0), "haltreq_o not one-hot");
      access(0, 8'h11, 0);
      v = resume_clears;
      access(1, 8'h10, 32'h4000_0001 | (32'(h) << 16));
      check(resumereq_o == ((h < `DM_NR_HARTS) ? 4'(1 << h) : 4'h0), "resumereq_o wrong");
      check(resume_clears == v + 1, "clear_resumeack_o did not pulse once");
      access(1, 8'h10, 32'h1 | (32'(h) << 16));
    end
    end_test("hart select");

    for (int i = 0; i < 8; i++) begin
      v = rand32();
      halted_i = v[3:0];
      unavailable_i = v[7:4];
      resumeack_i = v[11:8];
      h = rand32() % 4;
      access(1, 8'h10, 32'h1 | (32'(h) << 16));
      access(0, 8'h11, 0);
      access(0, 8'h40, 0);
      access(1, 8'h10, 32'h1000_0001 | (32'(h) << 16));
      access(0, 8'h11, 0);
    end
    end_test("dmstatus");

    // ------------------------------------------------------
    // abstract command registers
    // ------------------------------------------------------
    for (int i = 0; i < 12; i++) begin
      w = rand32();
      v = (i % 2) ? (8'h04 + (i / 2) % `DM_DATA_COUNT) :
                    (8'h20 + (i / 2) % `DM_PROGBUF_SIZE);
      access(1, v[7:0], w);
      access(0, v[7:0], 0);
      check(data_o[(i / 2) % `DM_DATA_COUNT] == m_data[(i / 2) % `DM_DATA_COUNT],
            "data_o mismatch");
      check(progbuf_o[(i / 2) % `DM_PROGBUF_SIZE] == m_prog[(i / 2) % `DM_PROGBUF_SIZE],
            "progbuf_o mismatch");
    end
    v = pulses;
    w = rand32();
    access(1, 8'h17, w);
    @(posedge clk_i);
    #1;
    check(pulses == v + 1 && last_cmd == w && cmd_o == m_command,
          "command write did not give one cmd_valid_o pulse");
    end_test("data and command");

    cmdbusy_i = 1'b1;
    access(1, 8'h04, rand32());
    access(0, 8'h04, 0);
    access(0, 8'h16, 0);
    cmdbusy_i = 1'b0;
    access(1, 8'h16, 32'h700);
    access(0, 8'h16, 0);
    cmderror_valid_i = 1'b1;
    cmderror_i = CmdErrException;
    m_cmderr = 3'h3;
    @(posedge clk_i);
    #1;
    cmderror_i = CmdErrBus;
    send(1, 8'h16, 32'h700);
    m_cmderr = 3'h5;
    cmderror_valid_i = 1'b0;
    drain();
    access(0, 8'h16, 0);
    access(1, 8'h16, 32'h700);
    end_test("cmderr");

    // ------------------------------------------------------
    // back-pressure and DMI reset flush
    // ------------------------------------------------------
    dmi_resp_ready_i = 1'b0;
    send(1, 8'h04, rand32());
    send(0, 8'h04, 0);
    @(negedge clk_i);
    check(!dmi_req_ready_o && dmi_resp_valid_o, "ready still high with a full queue");
    @(posedge clk_i);
    #1 dmi_resp_ready_i = 1'b1;
    drain();
    dmi_resp_ready_i = 1'b0;
    send(0, 8'h05, 0);
    send(0, 8'h20, 0);
    dmi_rst_ni_i = 1'b0;
    @(posedge clk_i);
    #1 dmi_rst_ni_i = 1'b1;
    exp_data.delete();
    exp_code.delete();
    @(negedge clk_i);
    check(!dmi_resp_valid_o && dmi_req_ready_o, "queue not empty after DMI reset");
    @(posedge clk_i);
    #1 dmi_resp_ready_i = 1'b1;
    access(0, 8'h10, 0);
    end_test("queue");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- dm_csrs_top.sv
// ----------------------------------------------------------
// debug module register front: DMI in, CSRs, response queue
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_csrs_top
  import dmi_pkg::*;
  import dm_reg_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             dmi_rst_ni_i,
  input  logic                             dmi_req_valid_i,
  output logic                             dmi_req_ready_o,
  input  dmi_req_t                         dmi_req_i,
  output logic                             dmi_resp_valid_o,
  input  logic                             dmi_resp_ready_i,
  output dmi_resp_t                        dmi_resp_o,
  input  logic [`DM_NR_HARTS-1:0]          halted_i,
  input  logic [`DM_NR_HARTS-1:0]          unavailable_i,
  input  logic [`DM_NR_HARTS-1:0]          resumeack_i,
  output logic [`DM_NR_HARTS-1:0]          haltreq_o,
  output logic [`DM_NR_HARTS-1:0]          resumereq_o,
  output logic                             clear_resumeack_o,
  output logic                             ndmreset_o,
  output logic                             dmactive_o,
  output logic                             cmd_valid_o,
  output command_t                         cmd_o,
  input  logic                             cmderror_valid_i,
  input  cmderr_e                          cmderror_i,
  input  logic                             cmdbusy_i,
  output logic [`DM_DATA_COUNT-1:0][31:0]   data_o,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0] progbuf_o
);

  csr_access_t access;
  logic [31:0] hart_rdata, abs_rdata;
  logic        abs_busy, fifo_full, fifo_empty, resp_push;
  dmi_resp_t   resp_in;

  assign dmi_resp_valid_o = ~fifo_empty;

  dm_csr_decode i_decode (
    .dmi_req_valid_i (dmi_req_valid_i),
    .dmi_req_i       (dmi_req_i),
    .fifo_full_i     (fifo_full),
    .dmi_req_ready_o (dmi_req_ready_o),
    .access_o        (access),
    .hart_rdata_i    (hart_rdata),
    .abs_rdata_i     (abs_rdata),
    .abs_busy_i      (abs_busy),
    .resp_push_o     (resp_push),
    .resp_o          (resp_in)
  );

  dm_hart_ctrl i_hart_ctrl (
    .clk_i, .rst_ni,
    .access_i          (access),
    .halted_i, .unavailable_i, .resumeack_i,
    .rdata_o           (hart_rdata),
    .haltreq_o, .resumereq_o, .clear_resumeack_o,
    .ndmreset_o, .dmactive_o
  );

  dm_abstract_regs i_abstract (
    .clk_i, .rst_ni,
    .access_i         (access),
    .dmactive_i       (dmactive_o),
    .cmdbusy_i, .cmderror_valid_i, .cmderror_i,
    .rdata_o          (abs_rdata),
    .busy_o           (abs_busy),
    .cmd_valid_o, .cmd_o, .data_o, .progbuf_o
  );

  // DMI reset drops any queued answers
  dmi_resp_fifo #(
    .payload_t (dmi_resp_t),
    .DEPTH     (`DM_RESP_DEPTH)
  ) i_resp_fifo (
    .clk_i, .rst_ni,
    .flush_i (~dmi_rst_ni_i),
    .push_i  (resp_push),
    .data_i  (resp_in),
    .full_o  (fifo_full),
    .empty_o (fifo_empty),
    .pop_i   (dmi_resp_ready_i & ~fifo_empty),
    .data_o  (dmi_resp_o)
  );

endmodule

//--- dm_abstract_regs.sv
// ----------------------------------------------------------
// abstract command registers: abstractcs, command, data and
// program buffer, with busy refusal while a command runs
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_abstract_regs
  import dmi_pkg::*;
  import dm_reg_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  csr_access_t                      access_i,
  input  logic                             dmactive_i,
  input  logic                             cmdbusy_i,
  input  logic                             cmderror_valid_i,
  input  cmderr_e                          cmderror_i,
  output logic [31:0]                      rdata_o,
  output logic                             busy_o,
  output logic                             cmd_valid_o,
  output command_t                         cmd_o,
  output logic [`DM_DATA_COUNT-1:0][31:0]   data_o,
  output logic [`DM_PROGBUF_SIZE-1:0][31:0] progbuf_o
);

  localparam int unsigned DataCount = `DM_DATA_COUNT;
  localparam int unsigned ProgSize  = `DM_PROGBUF_SIZE;
  localparam int unsigned DIdxW     = (DataCount > 1) ? $clog2(DataCount) : 1;
  localparam int unsigned PIdxW     = (ProgSize > 1) ? $clog2(ProgSize) : 1;

  logic [DataCount-1:0][31:0] data_d, data_q;
  logic [ProgSize-1:0][31:0]  progbuf_d, progbuf_q;
  command_t                   command_d, command_q;
  cmderr_e                    cmderr_d, cmderr_q;
  logic                       cmd_valid_d, cmd_valid_q;
  abstractcs_t                abstractcs, acs_wr;
  logic [7:0]                 data_off, prog_off;
  logic [DIdxW-1:0]           data_idx;
  logic [PIdxW-1:0]           prog_idx;
  logic                       is_data, is_prog, is_acs, is_cmd;

  assign data_off = access_i.addr - 8'(Data0);
  assign prog_off = access_i.addr - 8'(ProgBuf0);
  assign data_idx = data_off[DIdxW-1:0];
  assign prog_idx = prog_off[PIdxW-1:0];
  assign is_data  = access_i.addr >= 8'(Data0) && data_off < 8'(DataCount);
  assign is_prog  = access_i.addr >= 8'(ProgBuf0) && prog_off < 8'(ProgSize);
  assign is_acs   = access_i.addr == 8'(AbstractCS);
  assign is_cmd   = access_i.addr == 8'(Command);
  assign acs_wr   = abstractcs_t'(access_i.wdata);

  // abstractcs stays readable so the debugger can poll busy
  assign busy_o = cmdbusy_i & ((access_i.rd & (is_data | is_prog)) |
                               (access_i.wr & (is_data | is_prog | is_acs | is_cmd)));

  always_comb begin
    abstractcs             = '0;
    abstractcs.progbufsize = 5'(ProgSize);
    abstractcs.datacount   = 4'(DataCount);
    abstractcs.busy        = cmdbusy_i;
    abstractcs.cmderr      = cmderr_q;
  end

  always_comb begin
    data_d      = data_q;
    progbuf_d   = progbuf_q;
    command_d   = command_q;
    cmderr_d    = cmderr_q;
    cmd_valid_d = 1'b0;
    if (busy_o) begin
      if (cmderr_q == CmdErrNone) begin
        cmderr_d = CmdErrBusy;
      end
    end else if (access_i.wr) begin
      if (is_data) begin
        data_d[data_idx] = access_i.wdata;
      end
      if (is_prog) begin
        progbuf_d[prog_idx] = access_i.wdata;
      end
      if (is_acs) begin
        cmderr_d = cmderr_e'(cmderr_q & ~acs_wr.cmderr);
      end
      if (is_cmd) begin
        command_d   = command_t'(access_i.wdata);
        cmd_valid_d = 1'b1;
      end
    end
    // error from the hart wins over a clear in the same cycle
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
  end

  // ----------------------------------------------------------
  // state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  // payload, cleared while the module is inactive
  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      data_q    <= '0;
      progbuf_q <= '0;
      command_q <= '0;
    end else begin
      data_q    <= data_d;
      progbuf_q <= progbuf_d;
      command_q <= command_d;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (is_data) begin
      rdata_o = data_q[data_idx];
    end
    if (is_prog) begin
      rdata_o = progbuf_q[prog_idx];
    end
    if (is_acs) begin
      rdata_o = abstractcs;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

  // no command launch out of a busy cycle
  a_no_cmd_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmdbusy_i |=> !cmd_valid_o);

endmodule

//--- dm_hart_ctrl.sv
// ----------------------------------------------------------
// dmcontrol, dmstatus and haltsum0 for the selected hart;
// drives the halt and resume requests into the harts
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_hart_ctrl
  import dmi_pkg::*;
  import dm_reg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  csr_access_t             access_i,
  input  logic [`DM_NR_HARTS-1:0] halted_i,
  input  logic [`DM_NR_HARTS-1:0] unavailable_i,
  input  logic [`DM_NR_HARTS-1:0] resumeack_i,
  output logic [31:0]             rdata_o,
  output logic [`DM_NR_HARTS-1:0] haltreq_o,
  output logic [`DM_NR_HARTS-1:0] resumereq_o,
  output logic                    clear_resumeack_o,
  output logic                    ndmreset_o,
  output logic                    dmactive_o
);

  localparam int unsigned NrHarts = `DM_NR_HARTS;
  localparam int unsigned SelW    = (NrHarts > 1) ? $clog2(NrHarts) : 1;

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  dmstatus_t          dmstatus;
  logic [NrHarts-1:0] havereset_d, havereset_q;
  logic [19:0]        hartsel;
  logic [SelW-1:0]    sel;
  logic               hart_exists;
  logic               sel_halted, sel_unavail, sel_havereset;
  logic               active;

  assign hartsel     = {dmcontrol_q.hartselhi, dmcontrol_q.hartsello};
  assign sel         = hartsel[SelW-1:0];
  assign hart_exists = hartsel < 20'(NrHarts);

  // state of the selected hart, zero when it does not exist
  assign sel_halted    = hart_exists & halted_i[sel];
  assign sel_unavail   = hart_exists & unavailable_i[sel];
  assign sel_havereset = hart_exists & havereset_q[sel];

  // registers only update while dmactive stays set across the edge
  assign active = dmcontrol_q.dmactive & dmcontrol_d.dmactive;

  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    havereset_d       = havereset_q;
    clear_resumeack_o = 1'b0;
    if (access_i.wr && access_i.addr == 8'(DMControl)) begin
      dmcontrol_d = dmcontrol_t'(access_i.wdata);
      if (dmcontrol_d.ackhavereset && hart_exists) begin
        havereset_d[sel] = 1'b0;
      end
    end
    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end
    // no hart array, no per-hart reset, no reset-halt
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = '0;
    dmcontrol_d.zero0           = '0;
    if (active && !dmcontrol_q.resumereq && dmcontrol_d.resumereq) begin
      clear_resumeack_o = 1'b1;
    end
    if (dmcontrol_q.resumereq && hart_exists && resumeack_i[sel]) begin
      dmcontrol_d.resumereq = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else if (!active) begin
      dmcontrol_q <= dmcontrol_t'({31'b0, dmcontrol_d.dmactive});
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  // ----------------------------------------------------------
  // status and read mux
  // ----------------------------------------------------------
  always_comb begin
    dmstatus                = '0;
    dmstatus.version        = DbgVersion013;
    dmstatus.authenticated  = 1'b1;
    dmstatus.allhavereset   = sel_havereset;
    dmstatus.anyhavereset   = sel_havereset;
    dmstatus.allresumeack   = hart_exists & resumeack_i[sel];
    dmstatus.anyresumeack   = hart_exists & resumeack_i[sel];
    dmstatus.allnonexistent = ~hart_exists;
    dmstatus.anynonexistent = ~hart_exists;
    dmstatus.allunavail     = sel_unavail;
    dmstatus.anyunavail     = sel_unavail;
    // running, halted and unavailable are exclusive
    dmstatus.allhalted      = sel_halted & ~sel_unavail;
    dmstatus.anyhalted      = sel_halted & ~sel_unavail;
    dmstatus.allrunning     = hart_exists & ~sel_halted & ~sel_unavail;
    dmstatus.anyrunning     = hart_exists & ~sel_halted & ~sel_unavail;
  end

  always_comb begin
    case (access_i.addr)
      8'(DMControl): rdata_o = dmcontrol_q;
      8'(DMStatus):  rdata_o = dmstatus;
      8'(HaltSum0):  rdata_o = 32'(halted_i);
      default:       rdata_o = '0;
    endcase
  end

  // one-hot requests towards the selected hart
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (hart_exists) begin
      haltreq_o[sel]   = dmcontrol_q.haltreq;
      resumereq_o[sel] = dmcontrol_q.resumereq;
    end
  end

  assign ndmreset_o = dmcontrol_q.ndmreset;
  assign dmactive_o = dmcontrol_q.dmactive;

  a_haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o));

endmodule

//--- dm_csr_decode.sv
// ----------------------------------------------------------
// DMI request decoder, turns an accepted request into a CSR
// access and builds the response word for the queue
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "dm_config.svh"

module dm_csr_decode
  import dmi_pkg::*;
  import dm_reg_pkg::*;
(
  input  logic        dmi_req_valid_i,
  input  dmi_req_t    dmi_req_i,
  input  logic        fifo_full_i,
  output logic        dmi_req_ready_o,
  output csr_access_t access_o,
  input  logic [31:0] hart_rdata_i,
  input  logic [31:0] abs_rdata_i,
  input  logic        abs_busy_i,
  output logic        resp_push_o,
  output dmi_resp_t   resp_o
);

  localparam logic [7:0] DataEnd    = 8'(Data0) + 8'(`DM_DATA_COUNT);
  localparam logic [7:0] ProgBufEnd = 8'(ProgBuf0) + 8'(`DM_PROGBUF_SIZE);

  logic       accept;
  logic [7:0] addr;
  logic       abs_sel;

  // a request is only taken when there is room for its answer
  assign dmi_req_ready_o = ~fifo_full_i;
  assign accept          = dmi_req_valid_i & dmi_req_ready_o;
  assign addr            = {1'b0, dmi_req_i.addr};

  always_comb begin
    access_o.rd    = accept && (dmi_req_i.op == DTM_READ);
    access_o.wr    = accept && (dmi_req_i.op == DTM_WRITE);
    access_o.addr  = addr;
    access_o.wdata = dmi_req_i.data;
  end

  // registers owned by the abstract command block
  always_comb begin
    abs_sel = 1'b0;
    if (addr >= 8'(Data0) && addr < DataEnd) begin
      abs_sel = 1'b1;
    end
    if (addr >= 8'(ProgBuf0) && addr < ProgBufEnd) begin
      abs_sel = 1'b1;
    end
    if (addr == 8'(AbstractCS) || addr == 8'(Command)) begin
      abs_sel = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // response word, one per accepted request
  // ----------------------------------------------------------
  assign resp_push_o = accept;

  always_comb begin
    resp_o.data = '0;
    resp_o.resp = DTM_SUCCESS;
    if (access_o.rd) begin
      resp_o.data = abs_sel ? abs_rdata_i : hart_rdata_i;
    end
    // refused while an abstract command runs
    if (abs_busy_i) begin
      resp_o.resp = DTM_BUSY;
    end
  end

endmodule

//--- dmi_resp_fifo.sv
// ----------------------------------------------------------
// small circular FIFO with a typed payload, synchronous flush
// ----------------------------------------------------------
`timescale 1ns/1ps

module dmi_resp_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 2
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     full_o,
  output logic     empty_o,
  input  logic     pop_i,
  output payload_t data_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t        mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrW:0]   count_q;
  logic            do_push, do_pop;

  assign full_o  = count_q == (PtrW + 1)'(DEPTH);
  assign empty_o = count_q == '0;
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    next_ptr = (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + (PtrW + 1)'(do_push) - (PtrW + 1)'(do_pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

//--- dm_reg_pkg.sv
// ----------------------------------------------------------
// debug register layouts and the decoded CSR access
// ----------------------------------------------------------
package dm_reg_pkg;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion013 = 4'h2;

  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       confstrptrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'h0,
    CmdErrBusy         = 3'h1,
    CmdErrNotSupported = 3'h2,
    CmdErrException    = 3'h3,
    CmdErrHaltResume   = 3'h4,
    CmdErrBus          = 3'h5,
    CmdErrOther        = 3'h7
  } cmderr_e;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    cmderr_e     cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  // one accepted DMI request, strobes already qualified
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } csr_access_t;

endpackage

//--- dmi_pkg.sv
// ----------------------------------------------------------
// DMI transport types shared by the debug transport and DM
// ----------------------------------------------------------
package dmi_pkg;

  // operation field of a DMI request
  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  // response code returned to the transport
  typedef enum logic [1:0] {
    DTM_SUCCESS = 2'h0,
    DTM_BUSY    = 2'h3
  } dtm_resp_e;

  typedef struct packed {
    logic [6:0]  addr;
    dtm_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    dtm_resp_e   resp;
  } dmi_resp_t;

  // debug CSR map, only the implemented subset
  typedef enum logic [7:0] {
    Data0      = 8'h04,
    DMControl  = 8'h10,
    DMStatus   = 8'h11,
    AbstractCS = 8'h16,
    Command    = 8'h17,
    ProgBuf0   = 8'h20,
    HaltSum0   = 8'h40
  } dm_csr_e;

endpackage

//--- dm_config.svh
// ----------------------------------------------------------
// debug module build configuration
// include wherever hart, data or queue sizes are needed
// ----------------------------------------------------------
`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// number of harts behind this debug module
`define DM_NR_HARTS 4

// abstract command data registers
`define DM_DATA_COUNT 2

// program buffer words
`define DM_PROGBUF_SIZE 4

// entries in the DMI response queue
`define DM_RESP_DEPTH 2

`endif
